// ==== rvExec.f ====
hdl/rvPkg.sv
hdl/stageIf.sv
hdl/instrDecoder.sv
hdl/aluExecute.sv
hdl/regFile.sv
hdl/resultStage.sv
hdl/rvExecTop.sv
tb/rvExecTb.sv

// ==== Makefile ====
# Verilator build and run of the rvExec testbench

LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --top-module rvExecTb -Mdir obj_dir -f rvExec.f
	./obj_dir/VrvExecTb | tee $(LOG)
	@grep -q "^all tests passed$$" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

// ==== tb/rvExecTests.mem ====
// instr    pc       rdAddr rdData  rdWrite nextPc  branchTaken illegal
// one instruction per line, issued in this order
FFB00093 00000100 01 FFFFFFFB 1 00000104 0 0 // addi x1, x0, -5
00300113 00000104 02 00000003 1 00000108 0 0 // addi x2, x0, 3
402081B3 00000108 03 FFFFFFF8 1 0000010C 0 0 // sub x3, x1, x2
00208233 0000010C 04 FFFFFFFE 1 00000110 0 0 // add x4, x1, x2
0020A2B3 00000110 05 00000001 1 00000114 0 0 // slt x5, x1, x2
0020B333 00000114 06 00000000 1 00000118 0 0 // sltu x6, x1, x2
4010D393 00000118 07 FFFFFFFD 1 0000011C 0 0 // srai x7, x1, 1
0010D413 0000011C 08 7FFFFFFD 1 00000120 0 0 // srli x8, x1, 1
123454B7 00000120 09 12345000 1 00000124 0 0 // lui x9, 0x12345
00001517 00000124 0A 00001124 1 00000128 0 0 // auipc x10, 0x1
010005EF 00000128 0B 0000012C 1 00000138 1 0 // jal x11, +16
00548667 00000138 0C 0000013C 1 12345004 1 0 // jalr x12, 5(x9)
00208463 00000200 00 00000000 0 00000204 0 0 // beq x1, x2, +8
FE209CE3 00000204 00 00000000 0 000001FC 1 0 // bne x1, x2, -8
0020C463 00000208 00 00000000 0 00000210 1 0 // blt x1, x2, +8
0020D463 0000020C 00 00000000 0 00000210 0 0 // bge x1, x2, +8
0020E463 00000210 00 00000000 0 00000214 0 0 // bltu x1, x2, +8
FE20FCE3 00000214 00 00000000 0 0000020C 1 0 // bgeu x1, x2, -8
00700013 00000300 00 00000007 0 00000304 0 0 // addi x0, x0, 7
000006B3 00000304 0D 00000000 1 00000308 0 0 // add x13, x0, x0
7FF00713 00000308 0E 000007FF 1 0000030C 0 0 // addi x14, x0, 0x7ff
00E70733 0000030C 0E 00000FFE 1 00000310 0 0 // add x14, x14, x14
001747B3 00000310 0F FFFFF005 1 00000314 0 0 // xor x15, x14, x1
00279833 00000314 10 FFFF8028 1 00000318 0 0 // sll x16, x15, x2
0000A283 00000400 00 00000000 0 00000404 0 1 // lw x5, 0(x1)
0020A023 00000404 00 00000000 0 00000408 0 1 // sw x2, 0(x1)
022082B3 00000408 00 00000000 0 0000040C 0 1 // mul x5, x1, x2
0000007F 0000040C 00 00000000 0 00000410 0 1 // unknown opcode
0002E8B3 00000410 11 00000001 1 00000414 0 0 // or x17, x5, x0

// ==== tb/rvExecTb.sv ====
// ==================================================
// rvExec testbench: vector file driver, in-order
// result checker, reset check and run watchdog
// ==================================================
`timescale 1ns/1ns

module rvExecTb;

    localparam int numVectors    = 29;
    localparam int vecWords      = 8; // words per vector line
    localparam int gapEvery      = 6; // idle cycle after every sixth instruction
    localparam int numGaps       = (numVectors - 1) / gapEvery;
    localparam int timeoutMargin = 20;
    localparam int cycleLimit    = numVectors + numGaps + timeoutMargin;
    localparam int resultLatency = 2; // sampling edge to registered outputs
    localparam int drainCycles   = resultLatency + 4;

    logic        clk = 1'b0;
    logic        rst;
    logic        instrValid;
    logic [31:0] instr;
    logic [31:0] pc;
    logic        resultValid;
    logic        illegal;
    logic [4:0]  rdAddr;
    logic [31:0] rdData;
    logic        rdWrite;
    logic [31:0] nextPc;
    logic        branchTaken;

    logic [31:0] vecMem [numVectors * vecWords];
    int          sampledEdge [numVectors]; // edge at which the decoder took it
    int          pending [$];              // issued, result not yet seen
    int          edgeCount  = 0;
    int          runCycles  = 0;
    int          errorCount = 0;
    int          checkCount = 0;

    rvExecTop #(
        .regCount (32)
    ) rvExecTop_i (
        .clk         (clk),
        .rst         (rst),
        .instrValid  (instrValid),
        .instr       (instr),
        .pc          (pc),
        .resultValid (resultValid),
        .illegal     (illegal),
        .rdAddr      (rdAddr),
        .rdData      (rdData),
        .rdWrite     (rdWrite),
        .nextPc      (nextPc),
        .branchTaken (branchTaken)
    );

    always #50 clk = ~clk; // 100 ns period

    always @(posedge clk) begin
        edgeCount <= edgeCount + 1;
        if (rst === 1'b0) begin
            runCycles <= runCycles + 1; // watchdog counts from reset release
        end
    end

    // ============ checks ============
    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("Error %s: got %h, expected %h", name, actual, expected);
        end
    endtask

    task automatic checkResult(input int idx);
        int base;
        base = idx * vecWords;
        checkValue($sformatf("rdAddr[%0d]", idx), {27'b0, rdAddr}, vecMem[base + 2]);
        checkValue($sformatf("rdData[%0d]", idx), rdData, vecMem[base + 3]);
        checkValue($sformatf("rdWrite[%0d]", idx), {31'b0, rdWrite}, vecMem[base + 4]);
        checkValue($sformatf("nextPc[%0d]", idx), nextPc, vecMem[base + 5]);
        checkValue($sformatf("branchTaken[%0d]", idx), {31'b0, branchTaken},
                   vecMem[base + 6]);
        checkValue($sformatf("illegal[%0d]", idx), {31'b0, illegal}, vecMem[base + 7]);
        if (edgeCount != sampledEdge[idx] + resultLatency) begin
            errorCount++;
            $display("instruction %0d reported at edge %0d instead of edge %0d",
                     idx, edgeCount, sampledEdge[idx] + resultLatency);
        end
    endtask

    task automatic finishRun();
        $display("checks: %0d, errors: %0d, left unreported: %0d",
                 checkCount, errorCount, pending.size());
        if (errorCount == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    endtask

    // ============ stimulus ============
    task automatic issueVector(input int idx);
        @(posedge clk);
        #10;
        instrValid       = 1'b1;
        instr            = vecMem[idx * vecWords];
        pc               = vecMem[idx * vecWords + 1];
        sampledEdge[idx] = edgeCount + 1; // taken at the next edge
        pending.push_back(idx);
    endtask

    // results are sampled mid-cycle, away from the drive time
    always @(negedge clk) begin
        if (rst === 1'b0 && resultValid === 1'b1) begin
            if (pending.size() == 0) begin
                errorCount++;
                $display("result strobe at edge %0d with no instruction pending", edgeCount);
            end else begin
                checkResult(pending.pop_front());
            end
        end
    end

    initial begin
        wait (runCycles >= cycleLimit);
        errorCount++;
        $display("timeout after %0d cycles with results still outstanding", cycleLimit);
        finishRun();
    end

    initial begin
        int waited;
        rst        = 1'b1;
        instrValid = 1'b0;
        instr      = '0;
        pc         = '0;
        $readmemh("tb/rvExecTests.mem", vecMem);
        repeat (5) @(posedge clk);
        #10;
        rst = 1'b0;

        checkValue("resultValid at reset", {31'b0, resultValid}, 32'd0);
        checkValue("rdWrite at reset", {31'b0, rdWrite}, 32'd0);
        checkValue("branchTaken at reset", {31'b0, branchTaken}, 32'd0);
        checkValue("illegal at reset", {31'b0, illegal}, 32'd0);

        for (int i = 0; i < numVectors; i++) begin
            issueVector(i);
            if (i % gapEvery == gapEvery - 1 && i != numVectors - 1) begin
                @(posedge clk);
                #10;
                instrValid = 1'b0; // one idle cycle
                instr      = '0;
            end
        end
        @(posedge clk);
        #10;
        instrValid = 1'b0;
        instr      = '0;

        waited = 0;
        while (pending.size() != 0 && waited < drainCycles) begin
            @(posedge clk);
            waited++;
        end
        if (pending.size() != 0) begin
            errorCount++;
            $display("%0d instructions were issued but never reported", pending.size());
        end
        repeat (3) @(posedge clk); // room for a stray strobe
        finishRun();
    end

endmodule

// ==== hdl/rvExecTop.sv ====
// ==================================================
// rvExec top: decode, execute, result stages and
// the register file
// ==================================================
`timescale 1ns/1ns

module rvExecTop #(
    parameter int regCount = 32
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        instrValid,
    input  logic [31:0] instr,
    input  logic [31:0] pc,
    output logic        resultValid,
    output logic        illegal,
    output logic [4:0]  rdAddr,
    output logic [31:0] rdData,
    output logic        rdWrite,
    output logic [31:0] nextPc,
    output logic        branchTaken
);

    logic [4:0]  rs1Addr;
    logic [4:0]  rs2Addr;
    logic [31:0] rs1Data;
    logic [31:0] rs2Data;
    logic        we;
    logic [4:0]  wAddr;
    logic [31:0] wData;

    decExIf decEx ();
    exResIf exRes ();

    instrDecoder #(
        .regCount (regCount)
    ) instrDecoder_i (
        .clk        (clk),
        .rst        (rst),
        .instrValid (instrValid),
        .instr      (instr),
        .pc         (pc),
        .ports      (decEx.dec)
    );

    aluExecute aluExecute_i (
        .clk     (clk),
        .rst     (rst),
        .decIn   (decEx.ex),
        .resOut  (exRes.ex),
        .rs1Addr (rs1Addr),
        .rs2Addr (rs2Addr),
        .rs1Data (rs1Data),
        .rs2Data (rs2Data)
    );

    regFile #(
        .regCount (regCount)
    ) regFile_i (
        .clk     (clk),
        .rst     (rst),
        .rs1Addr (rs1Addr),
        .rs2Addr (rs2Addr),
        .rs1Data (rs1Data),
        .rs2Data (rs2Data),
        .we      (we),
        .wAddr   (wAddr),
        .wData   (wData)
    );

    resultStage resultStage_i (
        .clk         (clk),
        .rst         (rst),
        .exIn        (exRes.res),
        .we          (we),
        .wAddr       (wAddr),
        .wData       (wData),
        .resultValid (resultValid),
        .illegal     (illegal),
        .rdAddr      (rdAddr),
        .rdData      (rdData),
        .rdWrite     (rdWrite),
        .nextPc      (nextPc),
        .branchTaken (branchTaken)
    );

endmodule

// ==== hdl/resultStage.sv ====
// ==================================================
// result stage: register write, bypass source and
// the registered outcome outputs
// ==================================================
`timescale 1ns/1ns

module resultStage (
    input  logic        clk,
    input  logic        rst,
    exResIf.res         exIn,
    output logic        we,
    output logic [4:0]  wAddr,
    output logic [31:0] wData,
    output logic        resultValid,
    output logic        illegal,
    output logic [4:0]  rdAddr,
    output logic [31:0] rdData,
    output logic        rdWrite,
    output logic [31:0] nextPc,
    output logic        branchTaken
);

    // commit only legal writes to a real register
    assign we    = exIn.rec.valid && !exIn.rec.illegal && exIn.rec.wbEn && exIn.rec.rd != 5'd0;
    assign wAddr = exIn.rec.rd;
    assign wData = exIn.rec.wbData;

    assign exIn.fwdValid = we; // same write, seen by execute this cycle
    assign exIn.fwdRd    = wAddr;
    assign exIn.fwdData  = wData;

    always_ff @(posedge clk) begin
        if (rst) begin
            resultValid <= 1'b0;
            illegal     <= 1'b0;
            rdWrite     <= 1'b0;
            branchTaken <= 1'b0;
        end else begin
            resultValid <= exIn.rec.valid; // one strobe per instruction
            illegal     <= exIn.rec.valid && exIn.rec.illegal;
            rdWrite     <= we;
            branchTaken <= exIn.rec.valid && exIn.rec.branchTaken;
        end
    end

    always_ff @(posedge clk) begin
        rdAddr <= exIn.rec.rd;
        rdData <= exIn.rec.wbData;
        nextPc <= exIn.rec.nextPc;
    end

endmodule

// ==== hdl/regFile.sv ====
// ==================================================
// integer register file, two async reads, one
// synchronous write, x0 held at zero
// ==================================================
`timescale 1ns/1ns

module regFile #(
    parameter int regCount = 32
) (
    input  logic        clk,
    input  logic        rst,
    input  logic [4:0]  rs1Addr,
    input  logic [4:0]  rs2Addr,
    output logic [31:0] rs1Data,
    output logic [31:0] rs2Data,
    input  logic        we,
    input  logic [4:0]  wAddr,
    input  logic [31:0] wData
);

    logic [31:0] regs [regCount];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < regCount; i++) begin
                regs[i] <= '0;
            end
        end else if (we && wAddr != 5'd0 && wAddr < regCount) begin
            regs[wAddr] <= wData; // x0 never written
        end
    end

    assign rs1Data = (rs1Addr < regCount) ? regs[rs1Addr] : '0;
    assign rs2Data = (rs2Addr < regCount) ? regs[rs2Addr] : '0;

endmodule

// ==== hdl/aluExecute.sv ====
// ==================================================
// execute stage: bypass, operand select, ALU,
// branch compare, next pc and the execute record
// ==================================================
`timescale 1ns/1ns

module aluExecute import rvPkg::*; (
    input  logic        clk,
    input  logic        rst,
    decExIf.ex          decIn,
    exResIf.ex          resOut,
    output logic [4:0]  rs1Addr,
    output logic [4:0]  rs2Addr,
    input  logic [31:0] rs1Data,
    input  logic [31:0] rs2Data
);

    decRec_t     rec;
    logic [31:0] rs1Val;
    logic [31:0] rs2Val;
    logic [31:0] opA;
    logic [31:0] opB;
    logic [31:0] aluRes;
    logic [31:0] pcPlus4;
    logic [31:0] pcPlusImm;
    logic        isEq;
    logic        isLt;
    logic        isLtu;
    logic        taken;
    exRec_t      recD;
    exRec_t      recQ;

    assign rec     = decIn.rec;
    assign rs1Addr = decIn.rs1Addr;
    assign rs2Addr = decIn.rs2Addr;

    // ============ operands ============
    // fwdValid is never set for x0, so no zero check here
    assign rs1Val = (resOut.fwdValid && resOut.fwdRd == decIn.rs1Addr) ?
                    resOut.fwdData : rs1Data;
    assign rs2Val = (resOut.fwdValid && resOut.fwdRd == decIn.rs2Addr) ?
                    resOut.fwdData : rs2Data;

    assign opA = rec.aSelPc ? rec.pc : rs1Val;
    assign opB = rec.bSelImm ? rec.imm : rs2Val;

    // ============ alu ============
    always_comb begin
        case (rec.aluOp)
            ALU_ADD:  aluRes = opA + opB;
            ALU_SUB:  aluRes = opA - opB;
            ALU_SLL:  aluRes = opA << opB[4:0];
            ALU_SLT:  aluRes = {31'b0, $signed(opA) < $signed(opB)};
            ALU_SLTU: aluRes = {31'b0, opA < opB};
            ALU_XOR:  aluRes = opA ^ opB;
            ALU_SRL:  aluRes = opA >> opB[4:0];
            ALU_SRA:  aluRes = $signed(opA) >>> opB[4:0];
            ALU_OR:   aluRes = opA | opB;
            ALU_AND:  aluRes = opA & opB;
            default:  aluRes = '0;
        endcase
    end

    // ============ branch resolve ============
    assign isEq  = (rs1Val ^ rs2Val) == 32'd0; // zero test
    assign isLt  = $signed(rs1Val) < $signed(rs2Val);
    assign isLtu = rs1Val < rs2Val;

    always_comb begin
        case (rec.branchKind)
            BR_EQ:   taken = isEq;
            BR_NE:   taken = !isEq;
            BR_LT:   taken = isLt;
            BR_GE:   taken = !isLt;
            BR_LTU:  taken = isLtu;
            BR_GEU:  taken = !isLtu;
            BR_JAL:  taken = 1'b1;
            BR_JALR: taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    assign pcPlus4   = rec.pc + 32'd4;
    assign pcPlusImm = rec.pc + rec.imm;

    // ============ execute record ============
    always_comb begin
        recD.valid       = rec.valid;
        recD.illegal     = rec.illegal;
        recD.pc          = rec.pc;
        recD.branchTaken = taken;
        recD.rd          = rec.rd;
        recD.wbEn        = rec.wbEn;
        if (rec.branchKind == BR_JALR) begin
            recD.nextPc = {aluRes[31:1], 1'b0};
        end else if (taken) begin
            recD.nextPc = pcPlusImm;
        end else begin
            recD.nextPc = pcPlus4;
        end
        case (rec.wbSrc)
            WB_IMM:  recD.wbData = rec.imm;
            WB_LINK: recD.wbData = pcPlus4;
            default: recD.wbData = aluRes;
        endcase
        if (!rec.wbEn) begin
            recD.wbData = '0; // nothing to report for branches and illegal ops
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            recQ.valid <= 1'b0;
        end else begin
            recQ <= recD;
        end
    end

    assign resOut.rec = recQ;

endmodule

// ==== hdl/instrDecoder.sv ====
// ==================================================
// decode stage: opcode classification, legality,
// immediate build and the registered decode record
// ==================================================
`timescale 1ns/1ns

module instrDecoder import rvPkg::*; #(
    parameter int regCount = 32
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        instrValid,
    input  instrWord_u  instr,
    input  logic [31:0] pc,
    decExIf.dec         ports
);

    opcode_e     opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic        altBit; // instr[30], sub / sra select
    aluOp_e      aluOp;
    logic        aSelPc;
    logic        bSelImm;
    immKind_e    immKind;
    branchKind_e branchKind;
    wbSrc_e      wbSrc;
    logic        wbEn;
    logic        useRs1;
    logic        useRs2;
    logic        badOp;
    logic        badReg;
    logic        illegal;
    logic [31:0] imm;
    decRec_t     recD;
    decRec_t     recQ;

    assign opcode = instr.rType.opcode;
    assign funct3 = instr.rType.funct3;
    assign funct7 = instr.rType.funct7;
    assign altBit = funct7[5];

    function automatic aluOp_e aluFromFunct3(input logic [2:0] f3, input logic alt);
        aluOp_e op;
        case (f3)
            3'b000:  op = alt ? ALU_SUB : ALU_ADD;
            3'b001:  op = ALU_SLL;
            3'b010:  op = ALU_SLT;
            3'b011:  op = ALU_SLTU;
            3'b100:  op = ALU_XOR;
            3'b101:  op = alt ? ALU_SRA : ALU_SRL;
            3'b110:  op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    // ============ control decode ============
    always_comb begin
        aluOp      = ALU_ADD; // register-immediate add unless overridden
        aSelPc     = 1'b0;
        bSelImm    = 1'b1;
        immKind    = IMM_I;
        branchKind = BR_NONE;
        wbSrc      = WB_ALU;
        wbEn       = 1'b1;
        useRs1     = 1'b1;
        useRs2     = 1'b0;
        badOp      = 1'b0;
        case (opcode)
            OPC_OP_IMM: begin
                aluOp = aluFromFunct3(funct3, altBit && funct3 == 3'b101);
                if (funct3 == 3'b001 && funct7 != 7'b0) begin
                    badOp = 1'b1;
                end
                if (funct3 == 3'b101 && (funct7 & 7'b1011111) != 7'b0) begin
                    badOp = 1'b1;
                end
            end
            OPC_OP: begin
                immKind = IMM_NONE;
                bSelImm = 1'b0;
                useRs2  = 1'b1;
                aluOp   = aluFromFunct3(funct3, altBit);
                // catches the M extension (funct7 = 0000001) too
                if ((funct7 & 7'b1011111) != 7'b0) begin
                    badOp = 1'b1;
                end
                if (altBit && funct3 != 3'b000 && funct3 != 3'b101) begin
                    badOp = 1'b1;
                end
            end
            OPC_LUI: begin
                immKind = IMM_U;
                wbSrc   = WB_IMM;
                useRs1  = 1'b0;
            end
            OPC_AUIPC: begin
                immKind = IMM_U;
                aSelPc  = 1'b1; // pc + imm through the alu
                useRs1  = 1'b0;
            end
            OPC_JAL: begin
                immKind    = IMM_J;
                branchKind = BR_JAL;
                wbSrc      = WB_LINK;
                useRs1     = 1'b0;
            end
            OPC_JALR: begin
                branchKind = BR_JALR; // target is rs1 + imm from the alu
                wbSrc      = WB_LINK;
                badOp      = funct3 != 3'b000;
            end
            OPC_BRANCH: begin
                immKind = IMM_B;
                wbEn    = 1'b0;
                useRs2  = 1'b1;
                case (funct3)
                    3'b000:  branchKind = BR_EQ;
                    3'b001:  branchKind = BR_NE;
                    3'b100:  branchKind = BR_LT;
                    3'b101:  branchKind = BR_GE;
                    3'b110:  branchKind = BR_LTU;
                    3'b111:  branchKind = BR_GEU;
                    default: badOp = 1'b1;
                endcase
            end
            OPC_STORE: begin
                immKind = IMM_S; // decoded, then refused
                badOp   = 1'b1;
            end
            default: badOp = 1'b1; // loads and unknown opcodes
        endcase
    end

    // ============ immediate ============
    always_comb begin
        case (immKind)
            IMM_I: imm = {{20{instr.iType.imm11_0[11]}}, instr.iType.imm11_0};
            IMM_S: imm = {{20{instr.sType.imm11_5[6]}}, instr.sType.imm11_5,
                          instr.sType.imm4_0};
            IMM_B: imm = {{19{instr.bType.imm12}}, instr.bType.imm12, instr.bType.imm11,
                          instr.bType.imm10_5, instr.bType.imm4_1, 1'b0};
            IMM_U: imm = {instr.uType.imm31_12, 12'b0};
            IMM_J: imm = {{11{instr.jType.imm20}}, instr.jType.imm20,
                          instr.jType.imm19_12, instr.jType.imm11,
                          instr.jType.imm10_1, 1'b0};
            default: imm = '0;
        endcase
    end

    // indices beyond the file, only matters for a 16-entry file
    assign badReg = (useRs1 && instr.rType.rs1 >= regCount)
                 || (useRs2 && instr.rType.rs2 >= regCount)
                 || (wbEn && instr.rType.rd >= regCount);
    assign illegal = badOp || badReg;

    // ============ decode record ============
    always_comb begin
        recD.valid      = instrValid;
        recD.illegal    = illegal;
        recD.pc         = pc;
        recD.imm        = imm;
        recD.rs1        = (useRs1 && !illegal) ? instr.rType.rs1 : 5'd0; // unused reads x0
        recD.rs2        = (useRs2 && !illegal) ? instr.rType.rs2 : 5'd0;
        recD.rd         = (wbEn && !illegal) ? instr.rType.rd : 5'd0;
        recD.aluOp      = aluOp;
        recD.aSelPc     = aSelPc;
        recD.bSelImm    = bSelImm;
        recD.branchKind = illegal ? BR_NONE : branchKind;
        recD.wbSrc      = wbSrc;
        recD.wbEn       = wbEn && !illegal;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            recQ.valid <= 1'b0;
        end else begin
            recQ <= recD;
        end
    end

    assign ports.rec     = recQ;
    assign ports.rs1Addr = recQ.rs1;
    assign ports.rs2Addr = recQ.rs2;

endmodule

// ==== hdl/stageIf.sv ====
// ==================================================
// stage-to-stage links: decode to execute and
// execute to result, with the result bypass path
// ==================================================
`timescale 1ns/1ns

interface decExIf import rvPkg::*; ();
    decRec_t    rec;
    logic [4:0] rs1Addr; // copies of rec.rs1 / rec.rs2
    logic [4:0] rs2Addr;

    modport dec (
        output rec, rs1Addr, rs2Addr
    );
    modport ex (
        input rec, rs1Addr, rs2Addr
    );
endinterface

interface exResIf import rvPkg::*; ();
    exRec_t      rec;
    logic        fwdValid; // write committing this cycle
    logic [4:0]  fwdRd;
    logic [31:0] fwdData;

    modport ex (
        output rec,
        input  fwdValid, fwdRd, fwdData
    );
    modport res (
        input  rec,
        output fwdValid, fwdRd, fwdData
    );
endinterface

// ==== hdl/rvPkg.sv ====
// ==================================================
// shared types of the rvExec pipeline: opcodes, ALU
// ops, branch and immediate kinds, instruction
// formats and the two stage records
// ==================================================
package rvPkg;

    typedef enum logic [6:0] {
        OPC_LOAD   = 7'b0000011,
        OPC_OP_IMM = 7'b0010011,
        OPC_AUIPC  = 7'b0010111,
        OPC_STORE  = 7'b0100011,
        OPC_OP     = 7'b0110011,
        OPC_LUI    = 7'b0110111,
        OPC_BRANCH = 7'b1100011,
        OPC_JALR   = 7'b1100111,
        OPC_JAL    = 7'b1101111
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
    } aluOp_e;

    typedef enum logic [3:0] {
        BR_NONE, BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU, BR_JAL, BR_JALR
    } branchKind_e;

    typedef enum logic [1:0] {
        WB_ALU, WB_IMM, WB_LINK // link is pc + 4
    } wbSrc_e;

    typedef enum logic [2:0] {
        IMM_NONE, IMM_I, IMM_S, IMM_B, IMM_U, IMM_J
    } immKind_e;

    // ============ instruction word formats ============
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            opcode_e    opcode;
        } rType;
        struct packed {
            logic [11:0] imm11_0;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            opcode_e     opcode;
        } iType;
        struct packed {
            logic [6:0] imm11_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] imm4_0;
            opcode_e    opcode;
        } sType;
        struct packed {
            logic       imm12;
            logic [5:0] imm10_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] imm4_1;
            logic       imm11;
            opcode_e    opcode;
        } bType;
        struct packed {
            logic [19:0] imm31_12;
            logic [4:0]  rd;
            opcode_e     opcode;
        } uType;
        struct packed {
            logic       imm20;
            logic [9:0] imm10_1;
            logic       imm11;
            logic [7:0] imm19_12;
            logic [4:0] rd;
            opcode_e    opcode;
        } jType;
    } instrWord_u;

    // ============ stage records ============
    typedef struct packed {
        logic        valid;
        logic        illegal;
        logic [31:0] pc;
        logic [31:0] imm;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
        aluOp_e      aluOp;
        logic        aSelPc;  // operand a is the pc
        logic        bSelImm; // operand b is the immediate
        branchKind_e branchKind;
        wbSrc_e      wbSrc;
        logic        wbEn;
    } decRec_t;

    typedef struct packed {
        logic        valid;
        logic        illegal;
        logic [31:0] pc;
        logic [31:0] nextPc;
        logic        branchTaken;
        logic [4:0]  rd;
        logic        wbEn;
        logic [31:0] wbData;
    } exRec_t;

endpackage
